//--- project.f
common/common.sv
decode/control.sv
decode/imm_gen.sv
logic/register_file.sv
decode/decode_stage.sv
verification/tb_clock_gen.sv
verification/tb_decode_stage.sv

//--- Makefile
VERILATOR ?= verilator
TOP       ?= tb_decode_stage
FILELIST  ?= project.f
BUILD_DIR ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --binary --timing --assert
PASS_MSG  ?= Done: no errors

.PHONY: sim clean

sim:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -Mdir $(BUILD_DIR) -f $(FILELIST)
	./$(BUILD_DIR)/V$(TOP) > $(LOG) 2>&1; cat $(LOG)
	grep -q "$(PASS_MSG)" $(LOG)

clean:
	rm -rf $(BUILD_DIR) $(LOG)

//--- verification/tb_decode_stage.sv
`timescale 1ns/1ps
`default_nettype none

module tb_decode_stage import common::*; ();

    logic            clk;
    logic            arst_n;
    logic            in_valid;
    logic [31:0]     instr;
    logic [31:0]     pc;
    logic            stall;
    logic            wb_en;
    logic [4:0]      wb_rd;
    logic [31:0]     wb_data;
    logic            out_valid;
    logic [31:0]     out_pc;
    logic [31:0]     rs1_data;
    logic [31:0]     rs2_data;
    logic [31:0]     imm;
    logic [4:0]      rd;
    logic [2:0]      funct3;
    encoding_type    encoding;
    alu_op_type      alu_op;
    logic            reg_write;
    logic            alu_src;
    logic            mem_read;
    logic            mem_write;
    logic            mem_to_reg;
    logic            is_branch;
    logic            illegal;

    // Model state, mirrors the ID/EX register
    logic [31:0]     model_regs [0:31];
    logic            exp_valid;
    logic [6:0]      exp_flags;
    logic [31:0]     exp_pc;
    logic [31:0]     exp_rs1;
    logic [31:0]     exp_rs2;
    logic [31:0]     exp_imm;
    logic [4:0]      exp_rd;
    logic [2:0]      exp_funct3;
    encoding_type    exp_enc;
    alu_op_type      exp_alu;
    logic            loaded;
    int              seed;
    int              errors;
    int              checks;

    tb_clock_gen u_clock_gen (.clk(clk));

    decode_stage UUT (
        .clk(clk), .arst_n(arst_n), .in_valid(in_valid), .instr(instr), .pc(pc),
        .stall(stall), .wb_en(wb_en), .wb_rd(wb_rd), .wb_data(wb_data),
        .out_valid(out_valid), .out_pc(out_pc), .rs1_data(rs1_data), .rs2_data(rs2_data),
        .imm(imm), .rd(rd), .funct3(funct3), .encoding(encoding), .alu_op(alu_op),
        .reg_write(reg_write), .alu_src(alu_src), .mem_read(mem_read),
        .mem_write(mem_write), .mem_to_reg(mem_to_reg), .is_branch(is_branch),
        .illegal(illegal)
    );

    function automatic encoding_type model_encoding(input logic [6:0] opc);
        case (opc)
            opcode_op_imm, opcode_load, opcode_jalr: return I_TYPE;
            opcode_store:                            return S_TYPE;
            opcode_branch:                           return B_TYPE;
            opcode_lui, opcode_auipc:                return U_TYPE;
            opcode_jal:                              return J_TYPE;
            default:                                 return R_TYPE;
        endcase
    endfunction

    // Bit order reg_write alu_src mem_read mem_write mem_to_reg is_branch illegal
    function automatic logic [6:0] model_flags(input logic [6:0] opc);
        case (opc)
            opcode_op:                return 7'b1000000;
            opcode_op_imm:            return 7'b1100000;
            opcode_load:              return 7'b1110100;
            opcode_store:             return 7'b0101000;
            opcode_branch:            return 7'b0000010;
            opcode_jal:               return 7'b1000010;
            opcode_jalr:              return 7'b1100010;
            opcode_lui, opcode_auipc: return 7'b1100000;
            default:                  return 7'b0000001;
        endcase
    endfunction

    function automatic alu_op_type model_alu(input logic [31:0] ins);
        logic alt;
        alt = (ins[31:25] == funct7_alt);
        if (ins[6:0] == opcode_op || ins[6:0] == opcode_op_imm) begin
            case (ins[14:12])
                3'd0:    return (alt && ins[6:0] == opcode_op) ? ALU_SUB : ALU_ADD;
                3'd1:    return ALU_SLL;
                3'd2:    return ALU_SLT;
                3'd3:    return ALU_SLTU;
                3'd4:    return ALU_XOR;
                3'd5:    return alt ? ALU_SRA : ALU_SRL;
                3'd6:    return ALU_OR;
                default: return ALU_AND;
            endcase
        end
        if (ins[6:0] == opcode_branch) begin
            case (ins[14:12])
                3'd0, 3'd1: return ALU_SUB;
                3'd4, 3'd5: return ALU_SLT;
                3'd6, 3'd7: return ALU_SLTU;
                default:    return ALU_ADD;
            endcase
        end
        return ALU_ADD;
    endfunction

    // Arithmetic shifts of the whole word give the sign extension
    function automatic logic [31:0] model_imm(input logic [31:0] ins, input encoding_type enc);
        logic [31:0] sra20;
        logic [31:0] sra19;
        logic [31:0] sra11;
        sra20 = $signed(ins) >>> 20;
        sra19 = $signed(ins) >>> 19;
        sra11 = $signed(ins) >>> 11;
        case (enc)
            I_TYPE: return sra20;
            S_TYPE: return (sra20 & 32'hffffffe0) | 32'(ins[11:7]);
            B_TYPE: return (sra19 & 32'hfffff000) | (32'(ins[7]) << 11)
                           | (32'(ins[30:25]) << 5) | (32'(ins[11:8]) << 1);
            U_TYPE: return ins & 32'hfffff000;
            J_TYPE: return (sra11 & 32'hfff00000) | (ins & 32'h000ff000)
                           | (32'(ins[20]) << 11) | (32'(ins[30:21]) << 1);
            default: return 32'd0;
        endcase
    endfunction

    function automatic logic [31:0] model_read(input logic [4:0] addr);
        if (addr == 5'd0) begin
            return 32'd0;
        end
        if (wb_en && wb_rd == addr) begin
            return wb_data;
        end
        return model_regs[addr];
    endfunction

    function automatic logic [6:0] group_opcode(input int idx);
        case (idx)
            0:       return opcode_op;
            1:       return opcode_op_imm;
            2:       return opcode_load;
            3:       return opcode_store;
            4:       return opcode_branch;
            5:       return opcode_jal;
            6:       return opcode_jalr;
            7:       return opcode_lui;
            default: return opcode_auipc;
        endcase
    endfunction

    function automatic logic [31:0] make_instr();
        logic [31:0] word;
        logic [31:0] pick;
        word = $random(seed);
        pick = $random(seed);
        // Now and then a fully random word, mostly illegal
        if (pick[3:0] == 4'hf) begin
            return word;
        end
        word[6:0] = group_opcode(int'(pick[7:4]) % 9);
        if (pick[9:8] != 2'b00) begin
            word[31:25] = pick[10] ? funct7_alt : 7'b0000000;
        end
        return word;
    endfunction

    task automatic drive_random();
        logic [31:0] r;
        logic [31:0] next_instr;
        r = $random(seed);
        next_instr = instr;
        // Fetch holds its instruction while the stage is stalled
        if (!stall) begin
            next_instr = make_instr();
            in_valid <= (r[3:0] < 4'd13);
            instr    <= next_instr;
            pc       <= pc + 32'd4;
        end
        stall   <= (r[7:4] < 4'd3);
        wb_en   <= r[8];
        wb_data <= $random(seed);
        // Aim write-back at a source register often, to hit the bypass
        case (r[10:9])
            2'b00:   wb_rd <= r[15:11];
            2'b01:   wb_rd <= next_instr[19:15];
            2'b10:   wb_rd <= next_instr[24:20];
            default: wb_rd <= 5'd0;
        endcase
    endtask

    task automatic check_field(input string name, input logic [31:0] expected,
                               input logic [31:0] actual);
        checks++;
        assert (actual === expected)
        else begin
            errors++;
            $display("ERR %0t %s expected %h actual %h", $time, name, expected, actual);
        end
    endtask

    task automatic wait_idle(input int limit);
        int n;
        n = 0;
        while (out_valid !== 1'b0 && n < limit) begin
            @(negedge clk);
            n++;
        end
        if (out_valid !== 1'b0) begin
            errors++;
            $display("Timeout: out_valid still high after %0d idle cycles", limit);
        end
    endtask

    // Model sees the inputs as they were before this edge
    always @(posedge clk) begin
        if (!arst_n) begin
            for (int i = 0; i < 32; i++) begin
                model_regs[i] = 32'd0;
            end
            exp_valid = 1'b0;
            exp_flags = 7'd0;
        end
        if (!stall) begin
            exp_pc     = pc;
            exp_rs1    = model_read(instr[19:15]);
            exp_rs2    = model_read(instr[24:20]);
            exp_enc    = model_encoding(instr[6:0]);
            exp_alu    = model_alu(instr);
            exp_imm    = model_imm(instr, exp_enc);
            exp_rd     = instr[11:7];
            exp_funct3 = instr[14:12];
            loaded     = 1'b1;
            if (arst_n) begin
                exp_valid = in_valid;
                exp_flags = in_valid ? model_flags(instr[6:0]) : 7'd0;
            end
        end
        if (arst_n && wb_en && wb_rd != 5'd0) begin
            model_regs[wb_rd] = wb_data;
        end
    end

    always @(negedge clk) begin
        if (loaded) begin
            check_field("out_valid", 32'(exp_valid), 32'(out_valid));
            check_field("reg_write", 32'(exp_flags[6]), 32'(reg_write));
            check_field("alu_src", 32'(exp_flags[5]), 32'(alu_src));
            check_field("mem_read", 32'(exp_flags[4]), 32'(mem_read));
            check_field("mem_write", 32'(exp_flags[3]), 32'(mem_write));
            check_field("mem_to_reg", 32'(exp_flags[2]), 32'(mem_to_reg));
            check_field("is_branch", 32'(exp_flags[1]), 32'(is_branch));
            check_field("illegal", 32'(exp_flags[0]), 32'(illegal));
            check_field("out_pc", exp_pc, out_pc);
            check_field("rs1_data", exp_rs1, rs1_data);
            check_field("rs2_data", exp_rs2, rs2_data);
            check_field("imm", exp_imm, imm);
            check_field("rd", 32'(exp_rd), 32'(rd));
            check_field("funct3", 32'(exp_funct3), 32'(funct3));
            check_field("encoding", 32'(exp_enc), 32'(encoding));
            check_field("alu_op", 32'(exp_alu), 32'(alu_op));
        end
    end

    initial begin
        seed     = 32'h908a15cb;
        errors   = 0;
        checks   = 0;
        loaded   = 1'b0;
        arst_n   = 1'b0;
        in_valid = 1'b0;
        instr    = 32'd0;
        pc       = 32'd0;
        stall    = 1'b0;
        wb_en    = 1'b0;
        wb_rd    = 5'd0;
        wb_data  = 32'd0;
        repeat (16) @(posedge clk);
        arst_n <= 1'b1;
        for (int cycle = 0; cycle < 3000; cycle++) begin
            @(posedge clk);
            drive_random();
        end
        @(posedge clk);
        in_valid <= 1'b0;
        stall    <= 1'b0;
        wb_en    <= 1'b0;
        wait_idle(20);
        @(negedge clk);
        $display("Checks: %0d, errors: %0d", checks, errors);
        if (errors == 0) begin
            $display("Done: no errors");
        end else begin
            $display("Done: errors found");
        end
        $finish;
    end

endmodule

`default_nettype wire

//--- verification/tb_clock_gen.sv
`timescale 1ns/1ps
`default_nettype none

module tb_clock_gen (
    output logic clk
);

    // 4 ns period
    initial begin
        clk = 1'b0;
    end

    always begin
        #2 clk = ~clk;
    end

endmodule

`default_nettype wire

//--- decode/decode_stage.sv
`timescale 1ns/1ps
`default_nettype none

module decode_stage import common::*; (
    input  logic                  clk,
    input  logic                  arst_n,
    input  logic                  in_valid,
    input  logic [xlen-1:0]       instr,
    input  logic [xlen-1:0]       pc,
    input  logic                  stall,
    input  logic                  wb_en,
    input  logic [reg_addr_w-1:0] wb_rd,
    input  logic [xlen-1:0]       wb_data,
    output logic                  out_valid,
    output logic [xlen-1:0]       out_pc,
    output logic [xlen-1:0]       rs1_data,
    output logic [xlen-1:0]       rs2_data,
    output logic [xlen-1:0]       imm,
    output logic [reg_addr_w-1:0] rd,
    output logic [2:0]            funct3,
    output encoding_type          encoding,
    output alu_op_type            alu_op,
    output logic                  reg_write,
    output logic                  alu_src,
    output logic                  mem_read,
    output logic                  mem_write,
    output logic                  mem_to_reg,
    output logic                  is_branch,
    output logic                  illegal
);

    encoding_type    dec_encoding;
    alu_op_type      dec_alu_op;
    logic            dec_reg_write;
    logic            dec_alu_src;
    logic            dec_mem_read;
    logic            dec_mem_write;
    logic            dec_mem_to_reg;
    logic            dec_is_branch;
    logic            dec_illegal;
    logic [xlen-1:0] dec_imm;
    logic [xlen-1:0] rf_rs1_data;
    logic [xlen-1:0] rf_rs2_data;
    logic            load;

    // Stage advances whenever execute is not holding it
    assign load = !stall;

    control u_control (
        .clk        (clk),
        .arst_n     (arst_n),
        .opcode     (instr[6:0]),
        .funct3     (instr[14:12]),
        .funct7     (instr[31:25]),
        .encoding   (dec_encoding),
        .alu_op     (dec_alu_op),
        .reg_write  (dec_reg_write),
        .alu_src    (dec_alu_src),
        .mem_read   (dec_mem_read),
        .mem_write  (dec_mem_write),
        .mem_to_reg (dec_mem_to_reg),
        .is_branch  (dec_is_branch),
        .illegal    (dec_illegal)
    );

    imm_gen u_imm_gen (
        .instr    (instr),
        .encoding (dec_encoding),
        .imm      (dec_imm)
    );

    register_file u_register_file (
        .clk      (clk),
        .arst_n   (arst_n),
        .rs1_addr (instr[19:15]),
        .rs2_addr (instr[24:20]),
        .wb_en    (wb_en),
        .wb_rd    (wb_rd),
        .wb_data  (wb_data),
        .rs1_data (rf_rs1_data),
        .rs2_data (rf_rs2_data)
    );

    // ID/EX control part, cleared on a bubble
    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            out_valid  <= 1'b0;
            reg_write  <= 1'b0;
            alu_src    <= 1'b0;
            mem_read   <= 1'b0;
            mem_write  <= 1'b0;
            mem_to_reg <= 1'b0;
            is_branch  <= 1'b0;
            illegal    <= 1'b0;
        end else if (load) begin
            out_valid  <= in_valid;
            reg_write  <= in_valid & dec_reg_write;
            alu_src    <= in_valid & dec_alu_src;
            mem_read   <= in_valid & dec_mem_read;
            mem_write  <= in_valid & dec_mem_write;
            mem_to_reg <= in_valid & dec_mem_to_reg;
            is_branch  <= in_valid & dec_is_branch;
            illegal    <= in_valid & dec_illegal;
        end
    end

    // ID/EX payload part
    always_ff @(posedge clk) begin
        if (load) begin
            out_pc   <= pc;
            rs1_data <= rf_rs1_data;
            rs2_data <= rf_rs2_data;
            imm      <= dec_imm;
            rd       <= instr[11:7];
            funct3   <= instr[14:12];
            encoding <= dec_encoding;
            alu_op   <= dec_alu_op;
        end
    end

    assert property (@(posedge clk) disable iff (!arst_n)
        !$isunknown(out_valid));

endmodule

`default_nettype wire

//--- logic/register_file.sv
`timescale 1ns/1ps
`default_nettype none

module register_file import common::*; (
    input  logic                  clk,
    input  logic                  arst_n,
    input  logic [reg_addr_w-1:0] rs1_addr,
    input  logic [reg_addr_w-1:0] rs2_addr,
    input  logic                  wb_en,
    input  logic [reg_addr_w-1:0] wb_rd,
    input  logic [xlen-1:0]       wb_data,
    output logic [xlen-1:0]       rs1_data,
    output logic [xlen-1:0]       rs2_data
);

    // x0 has no storage
    logic [xlen-1:0] regs [1:num_regs-1];

    // One read port, including write-back bypass
    function automatic logic [xlen-1:0] read_port(input logic [reg_addr_w-1:0] addr);
        if (addr == '0) begin
            return '0;
        end
        if (wb_en && wb_rd == addr) begin
            return wb_data;
        end
        return regs[addr];
    endfunction

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            for (int i = 1; i < num_regs; i++) begin
                regs[i] <= '0;
            end
        end else if (wb_en && wb_rd != '0) begin
            regs[wb_rd] <= wb_data;
        end
    end

    always_comb begin
        rs1_data = read_port(rs1_addr);
        rs2_data = read_port(rs2_addr);
    end

    // x0 reads zero even while a write targets it
    assert property (@(posedge clk)
        (rs1_addr == '0) |-> (rs1_data == '0));

    assert property (@(posedge clk)
        (rs2_addr == '0) |-> (rs2_data == '0));

endmodule

`default_nettype wire

//--- decode/imm_gen.sv
`timescale 1ns/1ps
`default_nettype none

module imm_gen import common::*; (
    input  logic [xlen-1:0] instr,
    input  encoding_type    encoding,
    output logic [xlen-1:0] imm
);

    logic sign;

    assign sign = instr[xlen-1];

    always_comb begin
        case (encoding)
            I_TYPE: begin
                imm = {{(xlen-12){sign}}, instr[31:20]};
            end
            S_TYPE: begin
                imm = {{(xlen-12){sign}}, instr[31:25], instr[11:7]};
            end
            B_TYPE: begin
                // Branch offsets are in halfwords
                imm = {{(xlen-13){sign}}, instr[31], instr[7], instr[30:25],
                       instr[11:8], 1'b0};
            end
            U_TYPE: begin
                imm = {instr[31:12], 12'b0};
            end
            J_TYPE: begin
                imm = {{(xlen-21){sign}}, instr[31], instr[19:12], instr[20],
                       instr[30:21], 1'b0};
            end
            default: begin
                // R type carries no immediate
                imm = '0;
            end
        endcase
    end

    // Jump and branch targets stay halfword aligned
    always_comb begin
        if (encoding == B_TYPE || encoding == J_TYPE) begin
            assert (imm[0] == 1'b0)
            else $error("imm_gen: odd %s immediate %h", encoding.name(), imm);
        end
    end

endmodule

`default_nettype wire

//--- decode/control.sv
`timescale 1ns/1ps
`default_nettype none

module control import common::*; (
    input  logic         clk,
    input  logic         arst_n,
    input  logic [6:0]   opcode,
    input  logic [2:0]   funct3,
    input  logic [6:0]   funct7,
    output encoding_type encoding,
    output alu_op_type   alu_op,
    output logic         reg_write,
    output logic         alu_src,
    output logic         mem_read,
    output logic         mem_write,
    output logic         mem_to_reg,
    output logic         is_branch,
    output logic         illegal
);

    logic alt;

    assign alt = (funct7 == funct7_alt);

    // Format and control flags per opcode group
    always_comb begin
        encoding   = R_TYPE;
        reg_write  = 1'b0;
        alu_src    = 1'b0;
        mem_read   = 1'b0;
        mem_write  = 1'b0;
        mem_to_reg = 1'b0;
        is_branch  = 1'b0;
        illegal    = 1'b0;

        case (opcode)
            opcode_op: begin
                encoding  = R_TYPE;
                reg_write = 1'b1;
            end
            opcode_op_imm: begin
                encoding  = I_TYPE;
                reg_write = 1'b1;
                alu_src   = 1'b1;
            end
            opcode_load: begin
                encoding   = I_TYPE;
                reg_write  = 1'b1;
                alu_src    = 1'b1;
                mem_read   = 1'b1;
                mem_to_reg = 1'b1;
            end
            opcode_jalr: begin
                encoding  = I_TYPE;
                reg_write = 1'b1;
                alu_src   = 1'b1;
                is_branch = 1'b1;
            end
            opcode_jal: begin
                encoding  = J_TYPE;
                reg_write = 1'b1;
                is_branch = 1'b1;
            end
            opcode_store: begin
                encoding  = S_TYPE;
                alu_src   = 1'b1;
                mem_write = 1'b1;
            end
            opcode_branch: begin
                encoding  = B_TYPE;
                is_branch = 1'b1;
            end
            opcode_lui, opcode_auipc: begin
                encoding  = U_TYPE;
                reg_write = 1'b1;
                alu_src   = 1'b1;
            end
            default: begin
                illegal = 1'b1;
            end
        endcase
    end

    // ALU operation select
    always_comb begin
        alu_op = ALU_ADD;
        case (opcode)
            opcode_op, opcode_op_imm: begin
                case (funct3)
                    // SUB only exists in the register form
                    f3_add_sub: alu_op = (alt && opcode == opcode_op) ? ALU_SUB : ALU_ADD;
                    f3_sll:     alu_op = ALU_SLL;
                    f3_slt:     alu_op = ALU_SLT;
                    f3_sltu:    alu_op = ALU_SLTU;
                    f3_xor:     alu_op = ALU_XOR;
                    f3_srl_sra: alu_op = alt ? ALU_SRA : ALU_SRL;
                    f3_or:      alu_op = ALU_OR;
                    f3_and:     alu_op = ALU_AND;
                    default:    alu_op = ALU_ADD;
                endcase
            end
            opcode_branch: begin
                case (funct3)
                    f3_beq, f3_bne:   alu_op = ALU_SUB;
                    f3_blt, f3_bge:   alu_op = ALU_SLT;
                    f3_bltu, f3_bgeu: alu_op = ALU_SLTU;
                    default:          alu_op = ALU_ADD;
                endcase
            end
            default: alu_op = ALU_ADD;
        endcase
    end

    // Illegal opcodes must never touch architectural state
    assert property (@(posedge clk) disable iff (!arst_n)
        illegal |-> !(reg_write || mem_write));

    assert property (@(posedge clk) disable iff (!arst_n)
        mem_read |-> mem_to_reg);

endmodule

`default_nettype wire

//--- common/common.sv
`default_nettype none

package common;

    // Datapath and register index widths
    localparam int xlen       = 32;
    localparam int reg_addr_w = 5;
    localparam int num_regs   = 2 ** reg_addr_w;

    // RV32I base opcode groups
    localparam logic [6:0] opcode_op     = 7'b0110011;
    localparam logic [6:0] opcode_op_imm = 7'b0010011;
    localparam logic [6:0] opcode_load   = 7'b0000011;
    localparam logic [6:0] opcode_store  = 7'b0100011;
    localparam logic [6:0] opcode_branch = 7'b1100011;
    localparam logic [6:0] opcode_jal    = 7'b1101111;
    localparam logic [6:0] opcode_jalr   = 7'b1100111;
    localparam logic [6:0] opcode_lui    = 7'b0110111;
    localparam logic [6:0] opcode_auipc  = 7'b0010111;

    // Selects SUB and SRA/SRAI
    localparam logic [6:0] funct7_alt = 7'b0100000;

    // funct3 for OP and OP_IMM
    localparam logic [2:0] f3_add_sub = 3'b000;
    localparam logic [2:0] f3_sll     = 3'b001;
    localparam logic [2:0] f3_slt     = 3'b010;
    localparam logic [2:0] f3_sltu    = 3'b011;
    localparam logic [2:0] f3_xor     = 3'b100;
    localparam logic [2:0] f3_srl_sra = 3'b101;
    localparam logic [2:0] f3_or      = 3'b110;
    localparam logic [2:0] f3_and     = 3'b111;

    // funct3 for BRANCH
    localparam logic [2:0] f3_beq  = 3'b000;
    localparam logic [2:0] f3_bne  = 3'b001;
    localparam logic [2:0] f3_blt  = 3'b100;
    localparam logic [2:0] f3_bge  = 3'b101;
    localparam logic [2:0] f3_bltu = 3'b110;
    localparam logic [2:0] f3_bgeu = 3'b111;

    // Instruction encoding format
    typedef enum logic [2:0] {
        R_TYPE,
        I_TYPE,
        S_TYPE,
        B_TYPE,
        U_TYPE,
        J_TYPE
    } encoding_type;

    // ALU operation handed to execute
    typedef enum logic [3:0] {
        ALU_ADD,
        ALU_SUB,
        ALU_SLL,
        ALU_SLT,
        ALU_SLTU,
        ALU_XOR,
        ALU_SRL,
        ALU_SRA,
        ALU_OR,
        ALU_AND
    } alu_op_type;

endpackage

`default_nettype wire
